// File: sed_link.f
+incdir+hw
hw/sed_pkg.sv
hw/sed_credit_fifo.sv
hw/sed_encoder.sv
hw/sed_fault_inject.sv
hw/sed_decoder.sv
hw/sed_error_stats.sv
hw/sed_link_top.sv
tests/sed_link_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the parity link testbench with Verilator
# A $fatal in the testbench gives a nonzero exit status
cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module sed_link_tb \
  -Mdir obj_dir \
  -f sed_link.f &&
./obj_dir/Vsed_link_tb &&
echo "run.sh: simulation finished" ||
{ echo "run.sh: build or simulation failed"; exit 1; }

// File: tests/sed_link_tb.sv
/* Parity link testbench with source and sink models,
   scoreboard, concurrent assertions and end-of-run statistics */
`timescale 1ns/1ps
`default_nettype none

`include "sed_link_defs.svh"

module sed_link_tb;

  localparam int NUM_BEATS    = 300;
  localparam int RESET_CYCLES = 16;
  // 20 cycles per beat plus the reset phase
  localparam int CYCLE_LIMIT  = 20 * NUM_BEATS + RESET_CYCLES;
  localparam int DATA_W       = `SED_DATA_WIDTH;
  localparam int CODE_W       = `SED_CODE_WIDTH;

  logic              clk;
  logic              rst_n;
  logic              in_valid;
  sed_pkg::sed_in_t  in_beat;
  logic              in_credit;
  logic              out_valid;
  sed_pkg::sed_dec_t out_result;
  logic              out_credit;
  logic [15:0]       err_count;
  logic              err_sticky;

  // Stimulus and scoreboard state
  integer            seed;
  sed_pkg::sed_in_t  sb_queue[$];
  int                src_credits;
  int                sent;
  int                received;
  int                credit_total;
  int                odd_masks;
  int                sink_level;
  int                stall;
  int                cycles = 0;
  logic              src_enable;
  logic              sink_hold;

  sed_link_top sed_link_top_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_beat    (in_beat),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_credit (out_credit),
    .err_count  (err_count),
    .err_sticky (err_sticky)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------------------------------------
  // Failure reporting helpers
  // --------------------------------------------------
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string test, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      abort_run($sformatf("** Error [%s] expected %0h actual %0h", test, exp, act));
    end
  endtask

  // Random fault mask of zero, one, two or three flips or any pattern
  function automatic logic [CODE_W-1:0] pick_mask();
    int                kind;
    int                b0;
    int                k1;
    int                k2;
    logic [CODE_W-1:0] mask;
    kind = $unsigned($random(seed)) % 8;
    b0   = $unsigned($random(seed)) % CODE_W;
    k1   = 1 + $unsigned($random(seed)) % 8;
    k2   = 1 + $unsigned($random(seed)) % 8;
    mask = '0;
    case (kind)
      0, 1, 2: mask = '0;
      3: mask[b0] = 1'b1;
      4: begin
        mask[b0]                 = 1'b1;
        mask[(b0 + k1) % CODE_W] = 1'b1;
      end
      // Offsets sum to at most 16 so all three bits differ
      5: begin
        mask[b0]                      = 1'b1;
        mask[(b0 + k1) % CODE_W]      = 1'b1;
        mask[(b0 + k1 + k2) % CODE_W] = 1'b1;
      end
      default: mask = CODE_W'($random(seed));
    endcase
    return mask;
  endfunction

  // Compare one output beat with the oldest sent beat
  task automatic check_result();
    sed_pkg::sed_in_t  beat;
    logic [CODE_W-1:0] exp_code;
    logic              exp_parity;
    logic              exp_due;
    string             test;
    if (sb_queue.size() == 0) begin
      abort_run("Output beat arrived while no sent beat was outstanding");
    end else begin
      beat = sb_queue.pop_front();
      test = (beat.flip == '0) ? "clean_path" : "detection";
      // Even weight over parity plus data
      exp_parity = ($countones(beat.data) % 2) == 1;
      exp_code   = {exp_parity, beat.data} ^ beat.flip;
      // Odd flip count is what a single parity bit can see
      exp_due    = ($countones(beat.flip) % 2) == 1;
      check_value({test, ".codeword"}, 32'(exp_code), 32'(out_result.codeword));
      check_value({test, ".data"}, 32'(beat.data ^ beat.flip[DATA_W-1:0]),
                  32'(out_result.data));
      check_value({test, ".syndrome"}, 32'(exp_due), 32'(out_result.syndrome));
      check_value({test, ".due"}, 32'(exp_due), 32'(out_result.due));
      if (beat.flip == '0) begin
        check_value("clean_path.weight", 32'd0, 32'($countones(out_result.codeword) % 2));
      end
    end
  endtask

  // --------------------------------------------------
  // Source and sink models on the falling edge
  // --------------------------------------------------
  always @(negedge clk) begin
    sed_pkg::sed_in_t beat;
    int unsigned      r;
    in_valid   = 1'b0;
    out_credit = 1'b0;
    if (rst_n) begin
      // Credit pulses are one cycle wide so each is seen once here
      if (in_credit) begin
        src_credits++;
        credit_total++;
      end
      if (src_enable && sent < NUM_BEATS && src_credits > 0 &&
          ($unsigned($random(seed)) % 4) != 0) begin
        beat.data = DATA_W'($random(seed));
        beat.flip = pick_mask();
        in_beat   = beat;
        in_valid  = 1'b1;
        sb_queue.push_back(beat);
        if (($countones(beat.flip) % 2) == 1) begin
          odd_masks++;
        end
        sent++;
        src_credits--;
      end
      // Sink accepts every presented beat into its small buffer
      if (out_valid) begin
        check_result();
        sink_level++;
        received++;
      end
      // Release entries sometimes after a random stall
      if (stall > 0) begin
        stall--;
      end else if (!sink_hold && sink_level > 0) begin
        out_credit = 1'b1;
        sink_level--;
        r = $unsigned($random(seed));
        if ((r % 64) == 0) begin
          stall = 40;
        end else if ((r % 4) == 0) begin
          stall = int'(r % 12);
        end
      end
    end
  end

  // --------------------------------------------------
  // Concurrent checks
  // --------------------------------------------------
  reset_values: assert property (@(negedge clk) (!rst_n && cycles > 0) |->
      (!in_credit && !out_valid && err_count == 16'd0 && !err_sticky))
    else abort_run($sformatf("** Error [reset_values] expected 0 0 0 0 actual %0b %0b %0h %0b",
                             in_credit, out_valid, err_count, err_sticky));

  credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
      credit_total <= sent)
    else abort_run($sformatf("** Error [credit_discipline] expected at most %0d actual %0d",
                             sent, credit_total));

  sink_space: assert property (@(negedge clk) disable iff (!rst_n)
      out_valid |-> (sink_level < `SED_SINK_CREDITS))
    else abort_run("Output beat arrived without a free sink entry");

  // Detected errors never outnumber the odd-weight masks sent so far
  stats_bound: assert property (@(posedge clk) disable iff (!rst_n)
      (err_count <= 16'(odd_masks)) && (!err_sticky || odd_masks != 0))
    else abort_run($sformatf("** Error [statistics.bound] expected at most %0d actual %0d",
                             odd_masks, err_count));

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      abort_run($sformatf("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT));
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    seed         = 34;
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_beat      = '0;
    out_credit   = 1'b0;
    src_enable   = 1'b0;
    sink_hold    = 1'b0;
    src_credits  = `SED_IN_DEPTH;
    sent         = 0;
    received     = 0;
    credit_total = 0;
    odd_masks    = 0;
    sink_level   = 0;
    stall        = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    src_enable = 1'b1;
    // Sink withholds credits for a while so all buffers fill
    while (sent < 100) @(posedge clk);
    sink_hold = 1'b1;
    repeat (80) @(posedge clk);
    sink_hold = 1'b0;
    // Drain everything still queued
    while (received < NUM_BEATS) @(posedge clk);
    repeat (4) @(posedge clk);
    @(negedge clk);
    if (sb_queue.size() == 0 && err_count == 16'(odd_masks) &&
        err_sticky == (odd_masks != 0)) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      // Count, sticky flag and beats left in the scoreboard
      abort_run($sformatf("** Error [statistics] expected %0d/%0b/0 actual %0d/%0b/%0d",
                          odd_masks, odd_masks != 0, err_count, err_sticky,
                          sb_queue.size()));
    end
  end

endmodule

`default_nettype wire

// File: hw/sed_link_top.sv
/* Parity link top: input buffer, encoder, fault injector,
   decoder, output buffer and error statistics */
`timescale 1ns/1ps
`default_nettype none

`include "sed_link_defs.svh"

module sed_link_top (
  input  logic              clk,
  input  logic              rst_n,
  // Source side
  input  logic              in_valid,
  input  sed_pkg::sed_in_t  in_beat,
  output logic              in_credit,
  // Sink side
  output logic              out_valid,
  output sed_pkg::sed_dec_t out_result,
  input  logic              out_credit,
  // Error statistics
  output logic [15:0]       err_count,
  output logic              err_sticky
);

  // Input buffer toward the encoder
  logic                inb_valid;
  sed_pkg::sed_in_t    inb_beat;
  // Credits returned by the output buffer
  logic                outb_credit;
  // Pipeline stage outputs
  logic                enc_valid;
  sed_pkg::sed_coded_t enc_coded;
  logic                inj_valid;
  sed_pkg::sed_code_t  inj_code;
  logic                dec_valid;
  sed_pkg::sed_dec_t   dec_result;

  // --------------------------------------------------
  // Input buffer
  // --------------------------------------------------
  // Holds as many credits as the output buffer has entries
  sed_credit_fifo #(
    .T       (sed_pkg::sed_in_t),
    .DEPTH   (`SED_IN_DEPTH),
    .CREDITS (`SED_OUT_DEPTH)
  ) in_buf (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid   (in_valid),
    .push_payload (in_beat),
    .up_credit    (in_credit),
    .pop_valid    (inb_valid),
    .pop_payload  (inb_beat),
    .down_credit  (outb_credit)
  );

  // --------------------------------------------------
  // Three-stage pipeline, no stall
  // --------------------------------------------------
  sed_encoder enc (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (inb_valid),
    .in_beat   (inb_beat),
    .out_valid (enc_valid),
    .out_coded (enc_coded)
  );

  sed_fault_inject inj (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (enc_valid),
    .in_coded  (enc_coded),
    .out_valid (inj_valid),
    .out_code  (inj_code)
  );

  sed_decoder dec (
    .clk        (clk),
    .rst_n      (rst_n),
    .rcv_valid  (inj_valid),
    .rcv_code   (inj_code),
    .dec_valid  (dec_valid),
    .dec_result (dec_result)
  );

  // --------------------------------------------------
  // Output buffer and statistics
  // --------------------------------------------------
  sed_credit_fifo #(
    .T       (sed_pkg::sed_dec_t),
    .DEPTH   (`SED_OUT_DEPTH),
    .CREDITS (`SED_SINK_CREDITS)
  ) out_buf (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid   (dec_valid),
    .push_payload (dec_result),
    .up_credit    (outb_credit),
    .pop_valid    (out_valid),
    .pop_payload  (out_result),
    .down_credit  (out_credit)
  );

  sed_error_stats stats (
    .clk        (clk),
    .rst_n      (rst_n),
    .dec_valid  (dec_valid),
    .dec_due    (dec_result.due),
    .err_count  (err_count),
    .err_sticky (err_sticky)
  );

endmodule

`default_nettype wire

// File: hw/sed_error_stats.sv
/* Detected-error statistics with a saturating count
   and a sticky flag */
`timescale 1ns/1ps
`default_nettype none

module sed_error_stats (
  input  logic        clk,
  input  logic        rst_n,
  // Decoder result qualifiers
  input  logic        dec_valid,
  input  logic        dec_due,
  // Statistics
  output logic [15:0] err_count,
  output logic        err_sticky
);

  logic hit;

  // Counted event is a valid beat with an error flagged
  assign hit = dec_valid && dec_due;

  // --------------------------------------------------
  // Counter and flag
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_count  <= '0;
      err_sticky <= 1'b0;
    end else if (hit) begin
      // Hold at all ones instead of wrapping
      if (err_count != '1) begin
        err_count <= err_count + 1'b1;
      end
      // Only reset clears this
      err_sticky <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/sed_decoder.sv
/* Single-error-detecting decoder stage: syndrome, error flag
   and uncorrected data, one registered cycle */
`timescale 1ns/1ps
`default_nettype none

module sed_decoder (
  input  logic               clk,
  input  logic               rst_n,
  // Received codeword from the channel
  input  logic               rcv_valid,
  input  sed_pkg::sed_code_t rcv_code,
  // Decoded result toward the output buffer
  output logic               dec_valid,
  output sed_pkg::sed_dec_t  dec_result
);

  logic              syndrome;
  logic              due;
  sed_pkg::sed_dec_t result;

  // --------------------------------------------------
  // Syndrome
  // --------------------------------------------------
  // Odd weight over the full word means an error
  assign syndrome = ^rcv_code;
  // Flag only on a real beat
  assign due = rcv_valid && syndrome;

  // One parity bit cannot locate a flip
  // so the message slice goes out as received
  always_comb begin
    result          = '0;
    result.codeword = rcv_code;
    result.syndrome = syndrome;
    result.due      = due;
    result.data     = rcv_code.data;
  end

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rcv_valid) begin
      dec_result <= result;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= rcv_valid;
    end
  end

endmodule

`default_nettype wire

// File: hw/sed_fault_inject.sv
/* Channel model stage that flips the masked codeword bits,
   one registered cycle */
`timescale 1ns/1ps
`default_nettype none

module sed_fault_inject (
  input  logic                clk,
  input  logic                rst_n,
  // Codeword plus mask from the encoder
  input  logic                in_valid,
  input  sed_pkg::sed_coded_t in_coded,
  // Possibly corrupted codeword toward the decoder
  output logic                out_valid,
  output sed_pkg::sed_code_t  out_code
);

  sed_pkg::sed_code_t noisy;

  // Each set mask bit inverts one codeword bit
  // Zero mask leaves the word clean
  assign noisy = in_coded.code ^ in_coded.flip;

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------
  // Mask is dropped here
  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_code <= noisy;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

endmodule

`default_nettype wire

// File: hw/sed_encoder.sv
/* Even-parity encoder stage, one registered cycle,
   passing the fault mask along with the codeword */
`timescale 1ns/1ps
`default_nettype none

module sed_encoder (
  input  logic                clk,
  input  logic                rst_n,
  // Beat from the input buffer
  input  logic                in_valid,
  input  sed_pkg::sed_in_t    in_beat,
  // Codeword toward the injector
  output logic                out_valid,
  output sed_pkg::sed_coded_t out_coded
);

  sed_pkg::sed_coded_t coded;

  // --------------------------------------------------
  // Parity generation
  // --------------------------------------------------
  // XOR of the message gives an even-weight codeword
  // Message bits pass through untouched in systematic form
  always_comb begin
    coded             = '0;
    coded.code.parity = ^in_beat.data;
    coded.code.data   = in_beat.data;
    coded.flip        = in_beat.flip;
  end

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------
  // Payload only loads on a valid beat
  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_coded <= coded;
    end
  end

  // Stage valid, never stalled
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

endmodule

`default_nettype wire

// File: hw/sed_credit_fifo.sv
/* Circular buffer with credit-gated registered pop,
   one upstream credit pulse per pop */
`timescale 1ns/1ps
`default_nettype none

module sed_credit_fifo #(
  parameter type T       = logic,
  parameter int  DEPTH   = 4,
  parameter int  CREDITS = 2
) (
  input  logic clk,
  input  logic rst_n,
  // Upstream side
  input  logic push_valid,
  input  T     push_payload,
  output logic up_credit,
  // Downstream side
  output logic pop_valid,
  output T     pop_payload,
  input  logic down_credit
);

  // Pointer, occupancy and credit counter widths
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int OW = $clog2(DEPTH + 1);
  localparam int CW = $clog2(CREDITS + 1);

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [OW-1:0] occ;
  logic [CW-1:0] credits;
  logic          do_pop;

  // Wrap a pointer at the last entry
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
    if (ptr == AW'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Send only with data on hand and a downstream credit held
  assign do_pop = (occ != '0) && (credits != '0);

  // --------------------------------------------------
  // Storage and output payload
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (push_valid) begin
      mem[wr_ptr] <= push_payload;
    end
  end

  always_ff @(posedge clk) begin
    if (do_pop) begin
      pop_payload <= mem[rd_ptr];
    end
  end

  // --------------------------------------------------
  // Control state
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      occ       <= '0;
      credits   <= CW'(CREDITS);
      pop_valid <= 1'b0;
      up_credit <= 1'b0;
    end else begin
      if (push_valid) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // Push and pop together keep the occupancy
      case ({push_valid, do_pop})
        2'b10:   occ <= occ + 1'b1;
        2'b01:   occ <= occ - 1'b1;
        default: occ <= occ;
      endcase
      // Returned credit and a send in one cycle cancel out
      case ({down_credit, do_pop})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
      // Freed entry goes back upstream with the beat
      pop_valid <= do_pop;
      up_credit <= do_pop;
    end
  end

endmodule

`default_nettype wire

// File: hw/sed_pkg.sv
/* Packed struct types shared by all stages of the parity link */
`default_nettype none

`include "sed_link_defs.svh"

package sed_pkg;

  // Beat offered by the external source
  typedef struct packed {
    logic [`SED_DATA_WIDTH-1:0] data;
    // Fault mask for this beat over the whole codeword
    logic [`SED_CODE_WIDTH-1:0] flip;
  } sed_in_t;

  // Systematic codeword with parity in the MSB
  typedef struct packed {
    logic                       parity;
    logic [`SED_DATA_WIDTH-1:0] data;
  } sed_code_t;

  // Encoder output still carrying its mask for the injector
  typedef struct packed {
    sed_code_t                  code;
    logic [`SED_CODE_WIDTH-1:0] flip;
  } sed_coded_t;

  // Decoder result as written into the output buffer
  typedef struct packed {
    sed_code_t                  codeword;
    logic                       syndrome;
    // Detected but uncorrectable error
    logic                       due;
    logic [`SED_DATA_WIDTH-1:0] data;
  } sed_dec_t;

endpackage

`default_nettype wire

// File: hw/sed_link_defs.svh
/* Sizing macros for the parity link: message and codeword widths,
   buffer depths and the credits held toward the sink */
`ifndef SED_LINK_DEFS_SVH
`define SED_LINK_DEFS_SVH

// --------------------------------------------------
// Word widths
// --------------------------------------------------
// Message word carried by each beat
`define SED_DATA_WIDTH 16
// One even-parity bit sits above the message
`define SED_CODE_WIDTH (`SED_DATA_WIDTH + 1)

// --------------------------------------------------
// Buffering and credits
// --------------------------------------------------
// Input buffer entries and initial source credits
`define SED_IN_DEPTH 4
// Output buffer entries and credits of the input buffer toward the pipeline
`define SED_OUT_DEPTH 8
// Sink buffer depth held by the output buffer after reset
`define SED_SINK_CREDITS 2

`endif
